// ==== Bender.yml ====
package:
  name: debug_unit

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/debug_cmd_pkg.sv
      - verilog/debug_bus_pkg.sv
      - verilog/debug_control_fsm.sv
      - verilog/program_loader.sv
      - verilog/report_serializer.sv
      - verilog/debug_unit.sv
  - target: simulation
    files:
      - verif/debug_clock_gen.sv
      - verif/debug_unit_assertions.sv
      - verif/debug_unit_tb.sv

// ==== all.f ====
+incdir+verilog
verilog/debug_cmd_pkg.sv
verilog/debug_bus_pkg.sv
verilog/debug_control_fsm.sv
verilog/program_loader.sv
verilog/report_serializer.sv
verilog/debug_unit.sv
verif/debug_clock_gen.sv
verif/debug_unit_assertions.sv
verif/debug_unit_tb.sv

// ==== verif/debug_clock_gen.sv ====
`timescale 1ns/1ns

module debug_clock_gen (
  output logic o_clock,
  output logic o_reset
);

  localparam int HALF_PERIOD = 10;  // 20 ns clock.
  localparam int RESET_CYCLES = 5;

  initial begin
    o_clock = 1'b0;
    forever #HALF_PERIOD o_clock = ~o_clock;
  end

  // Reset released on a falling edge, like every other DUT input.
  initial begin
    o_reset = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clock);
    @(negedge o_clock);
    o_reset = 1'b1;
  end

endmodule

// ==== verif/debug_unit_assertions.sv ====
`timescale 1ns/1ns

module debug_unit_assertions
  import debug_bus_pkg::*;
(
  input logic        i_clock,
  input logic        i_reset,
  input prog_write_t i_prog_write,
  input tx_req_t     i_tx,
  input logic        i_pc_enable,
  input logic        i_soft_reset
);

  int fail_count = 0;  // Failed assertions so far.

  //////////////////////////////////////////////////
  // Protocol rules on the DUT outputs
  //////////////////////////////////////////////////

  property single_cycle_write;
    @(posedge i_clock) disable iff (!i_reset)
      i_prog_write.write |=> !i_prog_write.write;
  endproperty

  property no_tx_while_running;
    @(posedge i_clock) disable iff (!i_reset)
      !(i_pc_enable && i_tx.start);
  endproperty

  property no_write_in_soft_reset;
    @(posedge i_clock) disable iff (!i_reset)
      !i_soft_reset |-> !i_prog_write.write;  // CPU held in reset.
  endproperty

  assert property (single_cycle_write)
    else begin
      $error("Program write held high for two cycles.");
      fail_count++;
    end
  assert property (no_tx_while_running)
    else begin
      $error("PC enable and tx start high together.");
      fail_count++;
    end
  assert property (no_write_in_soft_reset)
    else begin
      $error("Program write while the soft reset is active.");
      fail_count++;
    end

endmodule

bind debug_unit debug_unit_assertions debug_unit_assertions_i (
  .i_clock      (i_clock),
  .i_reset      (i_reset),
  .i_prog_write (o_prog_write),
  .i_tx         (o_tx),
  .i_pc_enable  (o_pc_enable),
  .i_soft_reset (o_soft_reset)
);

// ==== verif/debug_unit_tb.sv ====
`timescale 1ns/1ns

`include "debug_macros.svh"

module debug_unit_tb
  import debug_cmd_pkg::*;
  import debug_bus_pkg::*;
();

  localparam int ACK_DELAY = 3;         // CPU reset acknowledge latency.
  localparam int NUM_WORDS = 4;         // Program words per session.
  localparam int BYTE_GAP = 3;          // Host idle cycles after each byte.
  localparam int CYCLES_PER_STEP = 16;  // Budget for one table entry.
  localparam logic [31:0] LFSR_SEED = 32'd74911;

  typedef struct {
    string      name;
    logic [7:0] rx;
    bit         wait_tx;   // Wait for tx start before checking.
    tx_req_t    exp_tx;
    logic       exp_step;
    db_select_e exp_sel;
    int         exp_run_len;
    int         exp_srst_len;
  } step_t;

  logic        clock;
  logic        reset;
  logic        rx_done;
  logic [7:0]  rx_data;
  logic        soft_reset_ack;
  logic [31:0] instruction_fetch;
  logic [31:0] database;
  tx_req_t     tx;
  logic        soft_reset;
  prog_write_t prog_write;
  logic        step_mode;
  logic        pc_enable;
  db_select_e  db_select;

  step_t       table_q[$];
  prog_write_t exp_writes[$];
  prog_write_t exp_write;
  logic [31:0] cpu_prog[$];
  logic [31:0] lfsr_state;
  int          fetch_idx;
  int          srst_cnt;
  int          srst_len;
  int          run_cnt;
  int          run_len;
  int          checks;
  int          errors;
  int          cycle_cnt;
  int          cycle_limit;

  debug_clock_gen debug_clock_gen_i (
    .o_clock (clock),
    .o_reset (reset)
  );

  debug_unit debug_unit_i (
    .i_clock             (clock),
    .i_reset             (reset),
    .i_rx_done           (rx_done),
    .i_rx_data           (rx_data),
    .i_soft_reset_ack    (soft_reset_ack),
    .i_instruction_fetch (instruction_fetch),
    .i_database          (database),
    .o_tx                (tx),
    .o_soft_reset        (soft_reset),
    .o_prog_write        (prog_write),
    .o_step_mode         (step_mode),
    .o_pc_enable         (pc_enable),
    .o_db_select         (db_select)
  );

  //////////////////////////////////////////////////
  // Expected values
  //////////////////////////////////////////////////

  function automatic logic [31:0] db_value(input db_select_e sel);
    case (sel)
      DB_RUN:      return 32'h0000_0001;
      DB_PC:       return 32'h0040_1A2C;
      DB_CYCLES:   return 32'h0000_3B71;
      DB_PC_PLUS4: return 32'h0040_1A30;
      DB_INSTR:    return 32'h8C49_5E02;
      default:     return 32'h0000_0000;
    endcase
  endfunction

  function automatic db_select_e report_select(input int k);
    if (k < 2) return DB_PC;
    if (k < 4) return DB_CYCLES;
    if (k < 6) return DB_PC_PLUS4;
    return DB_INSTR;
  endfunction

  // High lane first for the 16-bit fields, then instruction bytes 3 to 0.
  function automatic logic [7:0] report_byte(input int k);
    logic [31:0] word;
    int          lane;
    word = db_value(report_select(k));
    lane = (k < 6) ? ((k % 2 == 0) ? 1 : 0) : (9 - k);
    return word[lane*8 +: 8];
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1.
  endfunction

  function automatic logic [31:0] next_program_word();
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      word = {word[30:0], lfsr_state[0]};
    end
    return (word == '0) ? 32'h1 : word;  // Zero would end the load.
  endfunction

  //////////////////////////////////////////////////
  // Table construction
  //////////////////////////////////////////////////

  task automatic add_step(input string name, input logic [7:0] rx, input bit wait_tx,
                          input logic exp_start, input logic [7:0] exp_data,
                          input logic exp_step, input db_select_e exp_sel,
                          input int exp_run_len, input int exp_srst_len);
    step_t s;
    s.name         = name;
    s.rx           = rx;
    s.wait_tx      = wait_tx;
    s.exp_tx.start = exp_start;
    s.exp_tx.data  = exp_data;
    s.exp_step     = exp_step;
    s.exp_sel      = exp_sel;
    s.exp_run_len  = exp_run_len;
    s.exp_srst_len = exp_srst_len;
    table_q.push_back(s);
  endtask

  task automatic build_session(input bit single_step);
    logic [31:0] word;
    prog_write_t w;
    logic [7:0]  start_cmd;
    add_step("soft_reset", CMD_SOFT_RESET, 1, 1, CMD_PC_ACK, 0, DB_NONE, 0, ACK_DELAY + 1);
    add_step("stray_in_ack", 8'h55, 0, 1, CMD_PC_ACK, 0, DB_NONE, 0, 0);
    add_step("pc_ack", CMD_PC_ACK, 0, 0, 8'h00, 0, DB_NONE, 0, 0);
    for (int i = 0; i < NUM_WORDS; i++) begin
      word = next_program_word();
      w.write = 1'b1;
      w.addr  = i;
      w.data  = word;
      exp_writes.push_back(w);
      cpu_prog.push_back(word);  // The CPU runs what was loaded.
      for (int b = 3; b >= 0; b--) begin
        add_step($sformatf("load_w%0d_b%0d", i, b), word[b*8 +: 8], 0, 0, 8'h00, 0,
                 DB_NONE, 0, 0);
      end
    end
    cpu_prog.push_back(`DEBUG_HALT_WORD);
    for (int b = 3; b >= 0; b--) begin
      add_step($sformatf("terminator_b%0d", b), 8'h00, 0, 0, 8'h00, 0, DB_NONE, 0, 0);
    end
    start_cmd = single_step ? CMD_STEP : CMD_RUN;
    add_step(single_step ? "step" : "run", start_cmd, 1, 1, report_byte(0), single_step,
             report_select(0), NUM_WORDS + 1, 0);
    add_step("stray_in_report", CMD_REQ_PC_L, 0, 1, report_byte(0), single_step,
             report_select(0), 0, 0);
    for (int k = 0; k < `DEBUG_REPORT_STEPS - 1; k++) begin
      add_step($sformatf("request_%0d", k), 8'h08 * (k + 1), 0, 1, report_byte(k + 1),
               single_step, report_select(k + 1), 0, 0);
    end
    add_step("request_9", CMD_REQ_INSTR_0, 0, 0, 8'h00, 0, DB_NONE, 0, 0);
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic compare_field(input string name, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp)
      else begin
        errors++;
        $display("ERR %s %s: expected %0h, actual %0h", name, field, exp, act);
      end
  endtask

  task automatic check_outputs(input step_t s);
    compare_field(s.name, "tx", s.exp_tx, tx);
    compare_field(s.name, "soft_reset", 1'b1, soft_reset);  // Inactive high.
    compare_field(s.name, "pc_enable", 1'b0, pc_enable);
    compare_field(s.name, "step_mode", s.exp_step, step_mode);
    compare_field(s.name, "db_select", s.exp_sel, db_select);
    if (s.exp_run_len != 0) begin
      compare_field(s.name, "run_cycles", s.exp_run_len, run_len);
    end
    if (s.exp_srst_len != 0) begin
      compare_field(s.name, "soft_reset_cycles", s.exp_srst_len, srst_len);
    end
  endtask

  // Host byte, rx done held high for two cycles.
  task automatic send_byte(input logic [7:0] b);
    @(negedge clock);
    rx_data = b;
    rx_done = 1'b1;
    repeat (2) @(negedge clock);
    rx_done = 1'b0;
    repeat (BYTE_GAP) @(negedge clock);
  endtask

  //////////////////////////////////////////////////
  // CPU and database model
  //////////////////////////////////////////////////

  always @(posedge clock) begin
    if (reset) begin
      if (!soft_reset) begin
        srst_cnt <= srst_cnt + 1;
      end else if (srst_cnt != 0) begin
        srst_len <= srst_cnt;  // Length of the last soft reset.
        srst_cnt <= 0;
      end
      if (pc_enable) begin
        run_cnt <= run_cnt + 1;
        compare_field("run", "db_select", DB_RUN, db_select);
      end else if (run_cnt != 0) begin
        run_len <= run_cnt;
        run_cnt <= 0;
      end
      if (prog_write.write) begin
        if (exp_writes.size() == 0) begin
          errors++;
          $display("Unexpected program write at address %0h.", prog_write.addr);
        end else begin
          exp_write = exp_writes.pop_front();
          compare_field("prog_write", "write", exp_write, prog_write);
        end
      end
    end
  end

  always @(negedge clock) begin
    soft_reset_ack = (srst_cnt >= ACK_DELAY) ? 1'b0 : 1'b1;  // Active low.
    if (pc_enable && fetch_idx < cpu_prog.size()) begin
      instruction_fetch = cpu_prog[fetch_idx];
      fetch_idx++;
    end
    database = db_value(db_select);
  end

  //////////////////////////////////////////////////
  // Timeout
  //////////////////////////////////////////////////

  initial begin
    cycle_cnt = 0;
    @(posedge clock);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clock);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the session did not complete.", cycle_cnt);
    $display("Verification failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    step_t idle;
    rx_done           = 1'b0;
    rx_data           = 8'h00;
    soft_reset_ack    = 1'b1;
    instruction_fetch = 32'hFFFF_FFFF;
    database          = 32'h0000_0000;
    fetch_idx         = 0;
    srst_cnt          = 0;
    srst_len          = 0;
    run_cnt           = 0;
    run_len           = 0;
    checks            = 0;
    errors            = 0;
    lfsr_state        = LFSR_SEED;

    // Bytes other than the soft reset are ignored in IDLE.
    add_step("idle_pc_ack", CMD_PC_ACK, 0, 0, 8'h00, 0, DB_NONE, 0, 0);
    add_step("idle_step", CMD_STEP, 0, 0, 8'h00, 0, DB_NONE, 0, 0);
    add_step("idle_request", CMD_REQ_INSTR_0, 0, 0, 8'h00, 0, DB_NONE, 0, 0);
    build_session(1'b1);
    build_session(1'b0);
    cycle_limit = table_q.size() * CYCLES_PER_STEP + 20;

    idle.name     = "after_reset";
    idle.exp_tx   = '0;
    idle.exp_step = 1'b0;
    idle.exp_sel  = DB_NONE;
    idle.exp_run_len  = 0;
    idle.exp_srst_len = 0;
    wait (reset === 1'b1);
    @(negedge clock);
    check_outputs(idle);

    foreach (table_q[i]) begin
      send_byte(table_q[i].rx);
      if (table_q[i].wait_tx) begin
        while (!tx.start) @(negedge clock);
        repeat (2) @(negedge clock);  // Monitors record the lengths.
      end
      check_outputs(table_q[i]);
    end

    if (exp_writes.size() != 0) begin
      errors++;
      $display("%0d expected program writes never happened.", exp_writes.size());
    end

    if (debug_unit_i.debug_unit_assertions_i.fail_count != 0) begin
      errors += debug_unit_i.debug_unit_assertions_i.fail_count;
      $display("%0d protocol assertions failed.",
               debug_unit_i.debug_unit_assertions_i.fail_count);
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== verilog/debug_bus_pkg.sv ====
`include "debug_macros.svh"

package debug_bus_pkg;

  //////////////////////////////////////////////////
  // Byte streams to and from the UART
  //////////////////////////////////////////////////

  // Valid for one cycle per received byte.
  typedef struct packed {
    logic                     valid;
    logic [`DEBUG_BYTE_W-1:0] data;
  } rx_byte_t;

  // Start is a level, the UART samples it when idle.
  typedef struct packed {
    logic                     start;
    logic [`DEBUG_BYTE_W-1:0] data;
  } tx_req_t;

  //////////////////////////////////////////////////
  // Program memory write port
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                     write;
    logic [`DEBUG_ADDR_W-1:0] addr;
    logic [`DEBUG_WORD_W-1:0] data;
  } prog_write_t;

endpackage

// ==== verilog/debug_cmd_pkg.sv ====
`include "debug_macros.svh"

package debug_cmd_pkg;

  //////////////////////////////////////////////////
  // Host command codes
  //////////////////////////////////////////////////

  // Report requests step by 0x08, one per report byte.
  typedef enum logic [`DEBUG_BYTE_W-1:0] {
    CMD_SOFT_RESET   = 8'h00,
    CMD_PC_ACK       = 8'h01,
    CMD_RUN          = 8'h03,  // Bit 2 low, continuous.
    CMD_STEP         = 8'h07,  // Bit 2 high, single step.
    CMD_REQ_PC_H     = 8'h08,
    CMD_REQ_PC_L     = 8'h10,
    CMD_REQ_CYCLES_H = 8'h18,
    CMD_REQ_CYCLES_L = 8'h20,
    CMD_REQ_PC4_H    = 8'h28,
    CMD_REQ_PC4_L    = 8'h30,
    CMD_REQ_INSTR_3  = 8'h38,
    CMD_REQ_INSTR_2  = 8'h40,
    CMD_REQ_INSTR_1  = 8'h48,
    CMD_REQ_INSTR_0  = 8'h50
  } debug_cmd_e;

  typedef enum logic [2:0] {
    IDLE, SOFT_RESET, WAIT_PC_ACK, LOAD, WAIT_START, RUN, REPORT
  } debug_state_e;

  // Source the CPU puts on its database port.
  typedef enum logic [2:0] {
    DB_NONE     = 3'd0,
    DB_RUN      = 3'd1,
    DB_PC       = 3'd2,
    DB_CYCLES   = 3'd3,
    DB_PC_PLUS4 = 3'd4,
    DB_INSTR    = 3'd5
  } db_select_e;

endpackage

// ==== verilog/debug_control_fsm.sv ====
`timescale 1ns/1ns

`include "debug_macros.svh"

module debug_control_fsm
  import debug_cmd_pkg::*;
  import debug_bus_pkg::*;
(
  input  logic                     i_clock,
  input  logic                     i_reset,
  input  logic                     i_rx_done,
  input  logic [`DEBUG_BYTE_W-1:0] i_rx_data,
  input  logic                     i_soft_reset_ack,
  input  logic [`DEBUG_WORD_W-1:0] i_instruction_fetch,
  input  logic                     i_load_done,
  input  tx_req_t                  i_report_tx,
  input  logic                     i_report_done,
  input  db_select_e               i_report_select,
  output rx_byte_t                 o_rx_byte,
  output logic                     o_load_active,
  output logic                     o_report_active,
  output tx_req_t                  o_tx,
  output logic                     o_soft_reset,
  output logic                     o_step_mode,
  output logic                     o_pc_enable,
  output db_select_e               o_db_select
);

  debug_state_e state_q;
  debug_state_e state_next;
  logic         rx_done_q;
  logic         byte_event;
  logic         start_cmd;

  //////////////////////////////////////////////////
  // Byte event on the falling edge of rx done
  //////////////////////////////////////////////////

  assign byte_event = ~i_rx_done & rx_done_q;

  assign o_rx_byte.valid = byte_event;
  assign o_rx_byte.data  = i_rx_data;

  assign start_cmd = byte_event && (state_q == WAIT_START) &&
                     ((i_rx_data == CMD_RUN) || (i_rx_data == CMD_STEP));

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state_q   <= IDLE;
      rx_done_q <= 1'b0;
    end else begin
      state_q   <= state_next;
      rx_done_q <= i_rx_done;
    end
  end

  // Mode bit holds through RUN and REPORT.
  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      o_step_mode <= 1'b0;
    end else if (start_cmd) begin
      o_step_mode <= i_rx_data[2];  // Set by CMD_STEP only.
    end else if (state_q == REPORT && i_report_done) begin
      o_step_mode <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_next = state_q;
    case (state_q)
      IDLE: begin
        if (byte_event && i_rx_data == CMD_SOFT_RESET) begin
          state_next = SOFT_RESET;
        end
      end
      SOFT_RESET: begin
        if (!i_soft_reset_ack) begin  // CPU acknowledge, active low.
          state_next = WAIT_PC_ACK;
        end
      end
      WAIT_PC_ACK: begin
        if (byte_event && i_rx_data == CMD_PC_ACK) begin
          state_next = LOAD;
        end
      end
      LOAD: begin
        if (i_load_done) begin
          state_next = WAIT_START;
        end
      end
      WAIT_START: begin
        if (start_cmd) begin
          state_next = RUN;
        end
      end
      RUN: begin
        if (i_instruction_fetch == `DEBUG_HALT_WORD) begin
          state_next = REPORT;
        end
      end
      REPORT: begin
        if (i_report_done) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Session outputs
  //////////////////////////////////////////////////

  assign o_load_active   = (state_q == LOAD);
  assign o_report_active = (state_q == REPORT);
  assign o_soft_reset    = (state_q != SOFT_RESET);  // Active low.
  assign o_pc_enable     = (state_q == RUN);

  always_comb begin
    o_tx        = '0;
    o_db_select = DB_NONE;
    case (state_q)
      WAIT_PC_ACK: begin
        o_tx.start = 1'b1;  // Ready announcement.
        o_tx.data  = CMD_PC_ACK;
      end
      RUN: begin
        o_db_select = DB_RUN;
      end
      REPORT: begin
        o_tx        = i_report_tx;
        o_db_select = i_report_select;
      end
      default: begin
        o_tx = '0;
      end
    endcase
  end

endmodule

// ==== verilog/debug_macros.svh ====
`ifndef DEBUG_MACROS_SVH
`define DEBUG_MACROS_SVH

//////////////////////////////////////////////////
// Serial link and processor widths
//////////////////////////////////////////////////

`define DEBUG_BYTE_W 8          // UART byte.
`define DEBUG_WORD_W 32         // Instruction and database word.
`define DEBUG_ADDR_W 11         // Program memory address.

`define DEBUG_BYTES_PER_WORD 4  // Bytes per program word.

//////////////////////////////////////////////////
// Session constants
//////////////////////////////////////////////////

// Fetching this word stops the run and starts the report.
`define DEBUG_HALT_WORD 32'h0000_0000

`define DEBUG_REPORT_STEPS 10   // Bytes sent back after HALT.

`endif

// ==== verilog/debug_unit.sv ====
`timescale 1ns/1ns

`include "debug_macros.svh"

module debug_unit
  import debug_cmd_pkg::*;
  import debug_bus_pkg::*;
#(
  parameter logic [`DEBUG_WORD_W-1:0] HALT_WORD = `DEBUG_HALT_WORD
) (
  input  logic                     i_clock,
  input  logic                     i_reset,
  input  logic                     i_rx_done,
  input  logic [`DEBUG_BYTE_W-1:0] i_rx_data,
  input  logic                     i_soft_reset_ack,
  input  logic [`DEBUG_WORD_W-1:0] i_instruction_fetch,
  input  logic [`DEBUG_WORD_W-1:0] i_database,
  output tx_req_t                  o_tx,
  output logic                     o_soft_reset,
  output prog_write_t              o_prog_write,
  output logic                     o_step_mode,
  output logic                     o_pc_enable,
  output db_select_e               o_db_select
);

  rx_byte_t   rx_byte;
  tx_req_t    report_tx;
  db_select_e report_select;
  logic       load_active;
  logic       load_done;
  logic       report_active;
  logic       report_done;

  // The FSM decodes HALT from the shared macro, so both must agree.
  if (HALT_WORD != `DEBUG_HALT_WORD) begin : g_halt_check
    $error("HALT_WORD differs from DEBUG_HALT_WORD.");
  end

  debug_control_fsm debug_control_fsm_i (
    .i_clock             (i_clock),
    .i_reset             (i_reset),
    .i_rx_done           (i_rx_done),
    .i_rx_data           (i_rx_data),
    .i_soft_reset_ack    (i_soft_reset_ack),
    .i_instruction_fetch (i_instruction_fetch),
    .i_load_done         (load_done),
    .i_report_tx         (report_tx),
    .i_report_done       (report_done),
    .i_report_select     (report_select),
    .o_rx_byte           (rx_byte),
    .o_load_active       (load_active),
    .o_report_active     (report_active),
    .o_tx                (o_tx),
    .o_soft_reset        (o_soft_reset),
    .o_step_mode         (o_step_mode),
    .o_pc_enable         (o_pc_enable),
    .o_db_select         (o_db_select)
  );

  program_loader program_loader_i (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_load_active (load_active),
    .i_rx_byte     (rx_byte),
    .o_prog_write  (o_prog_write),
    .o_load_done   (load_done)
  );

  report_serializer report_serializer_i (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_report_active (report_active),
    .i_rx_byte       (rx_byte),
    .i_database      (i_database),
    .o_tx            (report_tx),
    .o_select        (report_select),
    .o_done          (report_done)
  );

endmodule

// ==== verilog/program_loader.sv ====
`timescale 1ns/1ns

`include "debug_macros.svh"

module program_loader
  import debug_bus_pkg::*;
(
  input  logic        i_clock,
  input  logic        i_reset,
  input  logic        i_load_active,
  input  rx_byte_t    i_rx_byte,
  output prog_write_t o_prog_write,
  output logic        o_load_done
);

  localparam int CNT_W = $clog2(`DEBUG_BYTES_PER_WORD);

  logic [`DEBUG_WORD_W-1:0] shift_q;
  logic [`DEBUG_WORD_W-1:0] word_next;
  logic [CNT_W-1:0]         byte_cnt_q;
  logic [`DEBUG_ADDR_W-1:0] addr_q;
  prog_write_t              write_q;
  logic                     done_q;
  logic                     word_event;
  logic                     word_zero;

  //////////////////////////////////////////////////
  // Word assembly, high byte first
  //////////////////////////////////////////////////

  assign word_next  = {shift_q[`DEBUG_WORD_W-`DEBUG_BYTE_W-1:0], i_rx_byte.data};
  assign word_event = i_rx_byte.valid &&
                      (byte_cnt_q == CNT_W'(`DEBUG_BYTES_PER_WORD - 1));
  assign word_zero  = (word_next == '0);  // Terminates the program.

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      shift_q    <= '0;
      byte_cnt_q <= '0;
    end else if (!i_load_active) begin
      shift_q    <= '0;
      byte_cnt_q <= '0;
    end else if (i_rx_byte.valid) begin
      shift_q    <= word_next;
      byte_cnt_q <= byte_cnt_q + 1'b1;  // Wraps every word.
    end
  end

  //////////////////////////////////////////////////
  // Write generation and address counter
  //////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      addr_q  <= '0;
      write_q <= '0;
      done_q  <= 1'b0;
    end else if (!i_load_active) begin
      addr_q  <= '0;
      write_q <= '0;
      done_q  <= 1'b0;
    end else begin
      write_q.write <= 1'b0;  // One cycle per word.
      done_q        <= 1'b0;
      if (word_event) begin
        write_q.write <= ~word_zero;
        write_q.addr  <= addr_q;
        write_q.data  <= word_next;
        done_q        <= word_zero;
      end
      if (write_q.write) begin
        addr_q <= addr_q + 1'b1;  // Next slot after the write.
      end
    end
  end

  assign o_prog_write = write_q;
  assign o_load_done  = done_q;

endmodule

// ==== verilog/report_serializer.sv ====
`timescale 1ns/1ns

`include "debug_macros.svh"

module report_serializer
  import debug_cmd_pkg::*;
  import debug_bus_pkg::*;
(
  input  logic                     i_clock,
  input  logic                     i_reset,
  input  logic                     i_report_active,
  input  rx_byte_t                 i_rx_byte,
  input  logic [`DEBUG_WORD_W-1:0] i_database,
  output tx_req_t                  o_tx,
  output db_select_e               o_select,
  output logic                     o_done
);

  localparam int STEP_W = $clog2(`DEBUG_REPORT_STEPS);
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`DEBUG_REPORT_STEPS - 1);

  logic [STEP_W-1:0]        step_q;
  logic [`DEBUG_BYTE_W-1:0] req_code;
  logic [1:0]               lane;
  db_select_e               select;
  logic                     req_match;

  //////////////////////////////////////////////////
  // Step counter
  //////////////////////////////////////////////////

  // Step k answers the code 0x08 * (k + 1).
  assign req_code  = CMD_REQ_PC_H * (step_q + 1'b1);
  assign req_match = i_report_active && i_rx_byte.valid && (i_rx_byte.data == req_code);

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      step_q <= '0;
    end else if (!i_report_active) begin
      step_q <= '0;
    end else if (req_match && step_q != LAST_STEP) begin
      step_q <= step_q + 1'b1;
    end
  end

  assign o_done = req_match && (step_q == LAST_STEP);

  //////////////////////////////////////////////////
  // Source and byte lane per step
  //////////////////////////////////////////////////

  always_comb begin
    case (step_q)
      4'd0, 4'd1: select = DB_PC;
      4'd2, 4'd3: select = DB_CYCLES;
      4'd4, 4'd5: select = DB_PC_PLUS4;
      default:    select = DB_INSTR;
    endcase
    if (step_q < 4'd6) begin
      lane = {1'b0, ~step_q[0]};  // High byte on even steps.
    end else begin
      lane = 2'(LAST_STEP - step_q);  // Instruction bytes 3 to 0.
    end
  end

  assign o_select   = i_report_active ? select : DB_NONE;
  assign o_tx.start = i_report_active;
  assign o_tx.data  = i_database[lane*`DEBUG_BYTE_W +: `DEBUG_BYTE_W];

endmodule
